/* dv/wave_input.txt */
# Columns: en_low conf amp sel cycles exp_strobes (all decimal).
# sel is 0 sine, 1 cosine, 2 triangle, 3 square; exp_strobes counts wr_en_o pulses seen.
# Idle after reset, nothing may come out.
1 0 0 0 5 0
# Configure amplitude 3, then run the sine past one full wrap.
1 1 3 0 2 0
0 0 3 0 70 67
# Switch shapes while generating.
0 0 3 1 20 20
0 0 3 2 20 20
0 0 3 3 20 20
# Leave GEN, the samples in flight still strobe.
1 0 3 3 4 3
# Back to GEN, the phase starts again at 0.
0 0 3 0 10 7
# Configuration request during GEN with a negative amplitude.
0 1 -8 3 2 2
0 0 -8 3 40 38
0 0 -8 2 64 64
# Reconfigure to amplitude 5 and run the cosine.
0 1 5 1 3 3
0 0 5 1 30 27
# Idle, then GEN again without a CONFI visit, so amp_i is ignored.
1 0 5 1 6 3
0 0 -3 2 25 22

/* src.f */
+incdir+hdl
hdl/wave_fmt_pkg.sv
hdl/wave_ctrl_pkg.sv
hdl/wave_ctrl_fsm.sv
hdl/phase_counter.sv
hdl/wave_table.sv
hdl/amp_scaler.sv
hdl/funct_generator.sv
dv/tb_funct_generator.sv

/* Bender.yml */
package:
  name: funct_generator

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/wave_fmt_pkg.sv
      - hdl/wave_ctrl_pkg.sv
      - hdl/wave_ctrl_fsm.sv
      - hdl/phase_counter.sv
      - hdl/wave_table.sv
      - hdl/amp_scaler.sv
      - hdl/funct_generator.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - dv/tb_funct_generator.sv

/* dv/tb_funct_generator.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_funct_generator;

	import wave_fmt_pkg::*;

	`include "sine_table.svh"

	// Model state encoding, kept separate from the RTL enum.
	localparam int S_IDLE = 0;
	localparam int S_CONF = 1;
	localparam int S_GEN  = 2;

	// Cycles allowed for the pipeline to empty after the last record.
	localparam int DRAIN_LIMIT = 20;

	logic                         clk;
	logic                         rst;
	logic                         en_low;
	logic                         enh_conf;
	logic signed [INT_BITS-1:0]   amp;
	wave_sel_t                    sel;
	logic signed [DATA_WIDTH-1:0] data;
	logic                         wr_en;

	// Reference model registers.
	int                           m_state;
	int                           m_phase;
	int                           m_amp;
	logic                         m_s1_valid;
	int                           m_s1_value;
	logic                         m_wr;
	logic signed [DATA_WIDTH-1:0] m_data;

	int errors;
	int strobes;
	int records;

	funct_generator uut (
		.clk        (clk),
		.rst        (rst),
		.en_low_i   (en_low),
		.enh_conf_i (enh_conf),
		.amp_i      (amp),
		.sel_i      (sel),
		.data_o     (data),
		.wr_en_o    (wr_en)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Shape value for phase k, straight from the wave rules.
	function automatic int wave_value(input int k, input int s);
		int v;
		case (s)
			0: v = SINE_LUT[k];
			1: v = SINE_LUT[(k + QUARTER) % LUT_DEPTH];
			2: begin
				if (k < 16) v = k * TRI_STEP;
				else if (k < 48) v = (32 - k) * TRI_STEP;
				else v = (k - LUT_DEPTH) * TRI_STEP;
			end
			default: v = (k < 32) ? WAVE_PEAK : -WAVE_PEAK;
		endcase
		return v;
	endfunction

	// Controller transitions; a configuration request always wins.
	function automatic int next_state(input int s, input logic en_l, input logic conf);
		int n;
		n = s;
		if (conf) n = S_CONF;
		else if (en_l) n = (s == S_GEN || s == S_CONF) ? S_IDLE : s;
		else n = S_GEN;
		return n;
	endfunction

	// The model steps on the same edge as the DUT, using the inputs that are stable there.
	// Stage two is computed first, so it sees the old sample and the old amplitude.
	always @(posedge clk) begin
		int full;
		if (rst) begin
			m_state    = S_IDLE;
			m_phase    = 0;
			m_amp      = 0;
			m_s1_valid = 1'b0;
			m_s1_value = 0;
			m_wr       = 1'b0;
			m_data     = '0;
		end else begin
			m_wr = m_s1_valid;
			if (m_s1_valid) begin
				full = m_s1_value * m_amp;
				// Every product must fit a signed 16-bit word.
				assert (full >= -32768 && full <= 32767) else begin
					errors++;
					$display("Model product %0d does not fit in 16 bits", full);
				end
				m_data = DATA_WIDTH'(full);
			end
			m_s1_valid = (m_state == S_GEN);
			m_s1_value = wave_value(m_phase, int'(sel));
			if (m_state == S_CONF) m_amp = int'(amp);
			m_phase = (m_state == S_GEN) ? (m_phase + 1) % LUT_DEPTH : 0;
			m_state = next_state(m_state, en_low, enh_conf);
		end
	end

	// Outputs are compared in the middle of the cycle, well away from the edges.
	// data_o is compared every cycle because it holds between strobes.
	always @(negedge clk) begin
		if (!rst) begin
			assert (wr_en === m_wr) else begin
				errors++;
				$display("Error: wr_en_o = %h, expected %h", wr_en, m_wr);
			end
			assert (data === m_data) else begin
				errors++;
				$display("Error: data_o = %h, expected %h", data, m_data);
			end
			if (wr_en === 1'b1) strobes++;
		end
	end

	// Holds one stimulus record for its cycle count and checks its strobe count.
	task automatic run_record(input int en_l, input int conf, input int amp_v,
	                          input int sel_v, input int cycles, input int exp_strobes);
		int mark;
		mark     = strobes;
		en_low   = en_l[0];
		enh_conf = conf[0];
		amp      = amp_v[INT_BITS-1:0];
		sel      = wave_sel_t'(sel_v[1:0]);
		repeat (cycles) begin
			@(posedge clk);
			#1;
		end
		assert (strobes - mark == exp_strobes) else begin
			errors++;
			$display("Error: wr_en_o strobe count = %h, expected %h in record %0d",
			         strobes - mark, exp_strobes, records);
		end
	endtask

	initial begin
		int    fd;
		int    rc;
		int    n;
		int    f_en;
		int    f_conf;
		int    f_amp;
		int    f_sel;
		int    f_cyc;
		int    f_exp;
		int    waited;
		logic  drained;
		string line;

		errors   = 0;
		strobes  = 0;
		records  = 0;
		rst      = 1'b1;
		en_low   = 1'b1;
		enh_conf = 1'b0;
		amp      = '0;
		sel      = WAVE_SIN;

		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;

		fd = $fopen("dv/wave_input.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("Could not open the stimulus file dv/wave_input.txt");
		end else begin
			while (!$feof(fd)) begin
				rc = $fgets(line, fd);
				// Lines starting with a hash are comments.
				if (rc != 0 && line.len() > 1 && line.getc(0) != "#") begin
					n = $sscanf(line, "%d %d %d %d %d %d",
					            f_en, f_conf, f_amp, f_sel, f_cyc, f_exp);
					if (n == 6) begin
						records++;
						run_record(f_en, f_conf, f_amp, f_sel, f_cyc, f_exp);
					end else begin
						errors++;
						$display("Malformed stimulus line: %s", line);
					end
				end
			end
			$fclose(fd);
		end

		assert (records > 0) else begin
			errors++;
			$display("No stimulus records were read");
		end

		// Park in IDLE and let the samples in flight come out.
		en_low   = 1'b1;
		enh_conf = 1'b0;
		waited   = 0;
		drained  = 1'b0;
		while (!drained && waited < DRAIN_LIMIT) begin
			@(negedge clk);
			waited++;
			if (!m_s1_valid && !m_wr && m_state != S_GEN && wr_en === 1'b0) drained = 1'b1;
		end
		assert (drained) else begin
			errors++;
			$display("Pipeline did not drain within %0d cycles", DRAIN_LIMIT);
		end

		$display("Records %0d, strobes %0d, errors %0d", records, strobes, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* hdl/funct_generator.sv */
`timescale 1ns/1ps
`default_nettype none

module funct_generator (
	input  logic                                       clk,
	input  logic                                       rst,
	input  logic                                       en_low_i,
	input  logic                                       enh_conf_i,
	input  logic signed [wave_fmt_pkg::INT_BITS-1:0]   amp_i,
	input  wave_fmt_pkg::wave_sel_t                    sel_i,
	output logic signed [wave_fmt_pkg::DATA_WIDTH-1:0] data_o,
	output logic                                       wr_en_o
);

	// Control word from the mode controller.
	wave_ctrl_pkg::gen_ctrl_t ctrl;

	// Phase and its consume flag into the table.
	logic [wave_fmt_pkg::LUT_ADDR-1:0] phase;
	logic                              advance;

	// Registered table sample into the scaler.
	wave_fmt_pkg::sample_t sample;

	// Mode controller, IDLE, CONFI and GEN.
	wave_ctrl_fsm u_ctrl (
		.clk        (clk),
		.rst        (rst),
		.en_low_i   (en_low_i),
		.enh_conf_i (enh_conf_i),
		.ctrl_o     (ctrl)
	);

	// Table address, cleared outside GEN and stepped inside it.
	phase_counter u_phase (
		.clk       (clk),
		.rst       (rst),
		.ctrl_i    (ctrl),
		.phase_o   (phase),
		.advance_o (advance)
	);

	// Shape lookup and selection, first pipeline stage.
	wave_table u_table (
		.clk       (clk),
		.rst       (rst),
		.phase_i   (phase),
		.advance_i (advance),
		.sel_i     (sel_i),
		.sample_o  (sample)
	);

	// Amplitude scaling and write strobe, second pipeline stage.
	amp_scaler u_scaler (
		.clk        (clk),
		.rst        (rst),
		.load_amp_i (ctrl.load_amp),
		.amp_i      (amp_i),
		.sample_i   (sample),
		.data_o     (data_o),
		.wr_en_o    (wr_en_o)
	);

endmodule

`default_nettype wire

/* hdl/amp_scaler.sv */
`timescale 1ns/1ps
`default_nettype none

module amp_scaler (
	input  logic                                       clk,
	input  logic                                       rst,
	input  logic                                       load_amp_i,
	input  logic signed [wave_fmt_pkg::INT_BITS-1:0]   amp_i,
	input  wave_fmt_pkg::sample_t                      sample_i,
	output logic signed [wave_fmt_pkg::DATA_WIDTH-1:0] data_o,
	output logic                                       wr_en_o
);

	import wave_fmt_pkg::*;

	logic signed [DATA_WIDTH-1:0] amp_q;
	logic signed [DATA_WIDTH-1:0] product;
	logic signed [DATA_WIDTH-1:0] data_q;
	logic                         wr_en_q;

	// Amplitude register.
	// The 4-bit input is sign-extended once here, so the multiplier sees equal widths.
	always_ff @(posedge clk) begin
		if (rst) begin
			amp_q <= '0;
		end else if (load_amp_i) begin
			amp_q <= {{(DATA_WIDTH - INT_BITS){amp_i[INT_BITS-1]}}, amp_i};
		end
	end

	// Signed multiply kept to DATA_WIDTH bits.
	// Table peaks of 4095 times |amp| <= 8 stay below 32768, so nothing is lost.
	assign product = sample_i.value * amp_q;

	// Output stage.
	// The strobe mirrors the sample valid bit one cycle later.
	// data_o only moves with a strobe and holds its last value otherwise.
	always_ff @(posedge clk) begin
		if (rst) begin
			data_q  <= '0;
			wr_en_q <= 1'b0;
		end else begin
			wr_en_q <= sample_i.valid;
			if (sample_i.valid) begin
				data_q <= product;
			end
		end
	end

	assign data_o  = data_q;
	assign wr_en_o = wr_en_q;

	// Each strobe answers a valid sample from the previous cycle.
	a_strobe_from_valid: assert property (@(posedge clk) disable iff (rst)
		wr_en_o |-> $past(sample_i.valid))
		else $error("wr_en_o without a valid sample, data_o=%h", data_o);

endmodule

`default_nettype wire

/* hdl/wave_table.sv */
`timescale 1ns/1ps
`default_nettype none

module wave_table (
	input  logic                              clk,
	input  logic                              rst,
	input  logic [wave_fmt_pkg::LUT_ADDR-1:0] phase_i,
	input  logic                              advance_i,
	input  wave_fmt_pkg::wave_sel_t           sel_i,
	output wave_fmt_pkg::sample_t             sample_o
);

	import wave_fmt_pkg::*;

	`include "sine_table.svh"

	// Phase breakpoints of the triangle and square shapes.
	localparam int HALF    = LUT_DEPTH / 2;
	localparam int THREE_Q = HALF + QUARTER;

	logic [LUT_ADDR-1:0]          cos_addr;
	int                           phase_int;
	int                           tri_k;
	logic signed [DATA_WIDTH-1:0] sin_val;
	logic signed [DATA_WIDTH-1:0] cos_val;
	logic signed [DATA_WIDTH-1:0] tri_val;
	logic signed [DATA_WIDTH-1:0] squ_val;
	logic signed [DATA_WIDTH-1:0] shape;
	logic                         valid_q;
	logic signed [DATA_WIDTH-1:0] value_q;

	// Cosine is the sine a quarter period ahead, wrapping inside the table.
	assign cos_addr = phase_i + LUT_ADDR'(QUARTER);
	assign sin_val  = SINE_LUT[phase_i];
	assign cos_val  = SINE_LUT[cos_addr];

	// The triangle follows the sine's zero crossings.
	// It rises to +16 steps at phase 16, falls to -16 at phase 48, then rises again.
	assign phase_int = int'(phase_i);

	always_comb begin
		if (phase_int < QUARTER) begin
			tri_k = phase_int;
		end else if (phase_int < THREE_Q) begin
			tri_k = HALF - phase_int;
		end else begin
			tri_k = phase_int - LUT_DEPTH;
		end
	end

	assign tri_val = DATA_WIDTH'(tri_k * TRI_STEP);

	// Square is high for the first half period and low for the second.
	assign squ_val = (phase_int < HALF) ? DATA_WIDTH'(WAVE_PEAK) : DATA_WIDTH'(-WAVE_PEAK);

	always_comb begin
		unique case (sel_i)
			WAVE_SIN: shape = sin_val;
			WAVE_COS: shape = cos_val;
			WAVE_TRI: shape = tri_val;
			WAVE_SQU: shape = squ_val;
		endcase
	end

	// The valid bit follows the consume flag of the presented phase.
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= advance_i;
		end
	end

	always_ff @(posedge clk) begin
		value_q <= shape;
	end

	assign sample_o = '{valid: valid_q, value: value_q};

	// A sample marked valid carries a fully known value into the scaler.
	a_valid_known: assert property (@(posedge clk) disable iff (rst)
		sample_o.valid |-> !$isunknown(sample_o.value))
		else $error("valid sample with unknown value %h", sample_o.value);

endmodule

`default_nettype wire

/* hdl/phase_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module phase_counter (
	input  logic                               clk,
	input  logic                               rst,
	input  wave_ctrl_pkg::gen_ctrl_t           ctrl_i,
	output logic [wave_fmt_pkg::LUT_ADDR-1:0]  phase_o,
	output logic                               advance_o
);

	import wave_fmt_pkg::*;

	logic [LUT_ADDR-1:0] phase_q;

	// Clear has priority, then advance, otherwise hold.
	// The adder is LUT_ADDR bits wide, so phase 63 wraps to 0 on its own.
	always_ff @(posedge clk) begin
		if (rst) begin
			phase_q <= '0;
		end else if (ctrl_i.clear_phase) begin
			phase_q <= '0;
		end else if (ctrl_i.gen_en) begin
			phase_q <= phase_q + 1'b1;
		end
	end

	// The current phase is consumed by the table in every GEN cycle.
	assign phase_o   = phase_q;
	assign advance_o = ctrl_i.gen_en;

	// A clear cycle leaves phase 0 for the next cycle.
	a_clear_zero: assert property (@(posedge clk) disable iff (rst)
		ctrl_i.clear_phase |=> (phase_o == '0))
		else $error("phase not cleared, phase_o=%h", phase_o);

	// An advance cycle leaves the next phase, modulo the table depth.
	a_advance_step: assert property (@(posedge clk) disable iff (rst)
		ctrl_i.gen_en |=> (phase_o == LUT_ADDR'($past(phase_o) + 1'b1)))
		else $error("phase did not step, phase_o=%h", phase_o);

endmodule

`default_nettype wire

/* hdl/wave_ctrl_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module wave_ctrl_fsm (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     en_low_i,
	input  logic                     enh_conf_i,
	output wave_ctrl_pkg::gen_ctrl_t ctrl_o
);

	import wave_ctrl_pkg::*;

	gen_state_t state_q;
	gen_state_t state_d;

	// State register.
	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// Next-state rules.
	// A configuration request wins over everything in every state.
	// Without it, en_low_i high parks the block in IDLE and low runs GEN.
	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (enh_conf_i) begin
					state_d = CONFI;
				end else if (!en_low_i) begin
					state_d = GEN;
				end
			end
			CONFI: begin
				if (enh_conf_i) begin
					state_d = CONFI;
				end else if (en_low_i) begin
					state_d = IDLE;
				end else begin
					state_d = GEN;
				end
			end
			GEN: begin
				if (enh_conf_i) begin
					state_d = CONFI;
				end else if (en_low_i) begin
					state_d = IDLE;
				end
			end
			// The unused encoding falls back to the reset state.
			default: state_d = IDLE;
		endcase
	end

	// Moore decode, so the control word depends on the state register only.
	always_comb begin
		ctrl_o.clear_phase = (state_q == IDLE) || (state_q == CONFI);
		ctrl_o.load_amp    = (state_q == CONFI);
		ctrl_o.gen_en      = (state_q == GEN);
	end

	// The phase counter must never see clear and advance together.
	a_clear_gen_excl: assert property (@(posedge clk) disable iff (rst)
		!(ctrl_o.clear_phase && ctrl_o.gen_en))
		else $error("clear_phase and gen_en both high");

	// Loading a new amplitude always restarts the phase from zero.
	a_load_clears: assert property (@(posedge clk) disable iff (rst)
		ctrl_o.load_amp |-> ctrl_o.clear_phase)
		else $error("load_amp without clear_phase");

endmodule

`default_nettype wire

/* hdl/wave_ctrl_pkg.sv */
`default_nettype none

package wave_ctrl_pkg;

	// Controller modes.
	// IDLE waits, CONFI takes a new amplitude and GEN runs the phase.
	typedef enum logic [1:0] {
		IDLE  = 2'd0,
		CONFI = 2'd1,
		GEN   = 2'd2
	} gen_state_t;

	// Control word decoded from the registered state.
	// clear_phase holds the phase at zero outside GEN.
	// load_amp opens the amplitude register in CONFI.
	// gen_en advances the phase in GEN.
	typedef struct packed {
		logic clear_phase;
		logic load_amp;
		logic gen_en;
	} gen_ctrl_t;

endpackage

`default_nettype wire

/* hdl/wave_fmt_pkg.sv */
`default_nettype none

package wave_fmt_pkg;

	// Width of every table sample and of the scaled output word.
	localparam int DATA_WIDTH = 16;

	// Width of the signed amplitude input, range -8 to 7.
	localparam int INT_BITS = 4;

	// The phase walks one table of LUT_DEPTH entries.
	localparam int LUT_ADDR = 6;
	localparam int LUT_DEPTH = 64;

	// A quarter period in phase steps.
	// Cosine reads the sine table this far ahead.
	localparam int QUARTER = 16;

	// Peak level of the square wave, equal to the sine peak.
	localparam int WAVE_PEAK = 4095;

	// Triangle slope per phase step, so the triangle peaks at 16 * 255 = 4080.
	// With |amp| <= 8 every product stays inside a signed 16-bit word.
	localparam int TRI_STEP = 255;

	// Shape selection as driven on sel_i.
	typedef enum logic [1:0] {
		WAVE_SIN = 2'd0,
		WAVE_COS = 2'd1,
		WAVE_TRI = 2'd2,
		WAVE_SQU = 2'd3
	} wave_sel_t;

	// One table sample on its way to the scaler.
	// The valid bit marks a phase that was consumed in GEN.
	typedef struct packed {
		logic                         valid;
		logic signed [DATA_WIDTH-1:0] value;
	} sample_t;

endpackage

`default_nettype wire

/* hdl/sine_table.svh */
// One full sine period in 64 steps.
// Entry k is round(4095 * sin(2 * pi * k / 64)).
// The second half is the first half negated, so the table is odd about entry 32.
// Values are signed 16 bit and peak at 4095 in entry 16.
localparam logic signed [15:0] SINE_LUT [0:63] = '{
	// The first quarter rises from zero to the peak.
	0, 401, 799, 1189,
	1567, 1930, 2275, 2598,
	2896, 3165, 3405, 3611,
	3783, 3919, 4016, 4075,
	// The second quarter falls back towards zero.
	4095, 4075, 4016, 3919,
	3783, 3611, 3405, 3165,
	2896, 2598, 2275, 1930,
	1567, 1189, 799, 401,
	// The third quarter falls to the negative peak.
	0, -401, -799, -1189,
	-1567, -1930, -2275, -2598,
	-2896, -3165, -3405, -3611,
	-3783, -3919, -4016, -4075,
	// The fourth quarter rises back towards zero.
	-4095, -4075, -4016, -3919,
	-3783, -3611, -3405, -3165,
	-2896, -2598, -2275, -1930,
	-1567, -1189, -799, -401
};
